// File: hdl/tenc_cfg.svh
// Bus width, FIFO depth, code-table size and field width macros
`ifndef TENC_CFG_SVH
`define TENC_CFG_SVH

// Management bus data width
`define TENC_WB_W 32

// FIFO address bits, depth is a power of two
`define TENC_RX_DEPTH_LOG2 4
`define TENC_TX_DEPTH_LOG2 8

// Code-parameter table
`define TENC_NUM_CODES 34
`define TENC_SEL_W 6

// Encoder configuration fields
`define TENC_BLOCKSIZE_W 10
`define TENC_PERM_P_W 10
`define TENC_PERM_Q_W 12

// Data fields of the stream payloads
`define TENC_SYM_DATA_W 2
`define TENC_RES_DATA_W 6

`endif

// File: hdl/tenc_pkg.sv
// Stream payload, configuration field, selector and bus word types
`include "tenc_cfg.svh"

package tenc_pkg;

    // Symbol written by the bus and sent to the encoder
    typedef struct packed {
        logic                          eof;
        logic                          bof;
        logic [`TENC_SYM_DATA_W-1:0]   data;
    } in_sym_t;

    // Encoded word returned by the encoder
    typedef struct packed {
        logic                          eof;
        logic                          bof;
        logic [`TENC_RES_DATA_W-1:0]   data;
    } res_word_t;

    // Code parameters handed to the encoder
    typedef logic [`TENC_BLOCKSIZE_W-1:0] blocksize_t;
    typedef logic [`TENC_PERM_P_W-1:0] perm_p_t;
    typedef logic [`TENC_PERM_Q_W-1:0] perm_q_t;

    // Table selector
    typedef logic [`TENC_SEL_W-1:0] code_sel_t;

    // Management bus word
    typedef logic [`TENC_WB_W-1:0] wb_data_t;

endpackage

// File: hdl/sync_fifo.sv
// Show-ahead synchronous FIFO with a type-parameter payload
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  ADDR_W    = 4
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_wr,
    input  logic     i_rd,
    input  payload_t i_w_data,
    output payload_t o_r_data,
    output logic     o_empty,
    output logic     o_full
);
    localparam int DEPTH = 1 << ADDR_W;

    payload_t mem [DEPTH];

    // Extra top bit on each pointer tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            wr_en;
    logic            rd_en;

    // Overflow and underflow requests are dropped here
    assign wr_en = i_wr & ~o_full;
    assign rd_en = i_rd & ~o_empty;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    always_ff @(posedge i_clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr[ADDR_W-1:0]] <= i_w_data;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Head word is valid whenever the FIFO is not empty, no read strobe needed
    assign o_r_data = mem[rd_ptr[ADDR_W-1:0]];

endmodule

// File: hdl/wb_regs.sv
// Wishbone slave with ack, push/pop decode, drain and readable flags, read-data assembly
module wb_regs
    import tenc_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_wb_cyc,
    input  logic      i_wb_stb,
    input  logic      i_wb_we,
    input  wb_data_t  i_wb_dat,
    output logic      o_wb_ack,
    output wb_data_t  o_wb_dat,
    output logic      o_rx_push,
    output in_sym_t   o_rx_sym,
    input  logic      i_rx_empty,
    output logic      o_drain,
    output logic      o_tx_pop,
    input  res_word_t i_tx_head,
    input  logic      i_tx_empty,
    input  logic      i_res_eof_accepted
);
    // Control bits of a bus write
    localparam int PUSH_BIT = 15;
    localparam int RDEN_BIT = 13;
    localparam int EOF_BIT  = 7;
    localparam int BOF_BIT  = 6;

    // Status bits of a bus read
    localparam int AVAIL_BIT = 15;
    localparam int ALIVE_BIT = 14;

    logic     req;
    logic     ack;
    logic     rd_en;
    logic     drain;
    logic     readable;
    wb_data_t rdata;

    assign req = i_wb_cyc & i_wb_stb;

    // Symbol is taken on the first cycle of the request, before ack
    assign o_rx_push = req & ~ack & i_wb_we & i_wb_dat[PUSH_BIT];

    assign o_rx_sym = '{
        eof:  i_wb_dat[EOF_BIT],
        bof:  i_wb_dat[BOF_BIT],
        data: i_wb_dat[1:0]
    };

    // Pop uses the read-enable left by an earlier request
    assign o_tx_pop = req & ack & rd_en;

    // One wait cycle, ack lasts exactly one clock
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= req & ~ack;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            rd_en <= 1'b0;
        end
        else if (req & ack)
        begin
            rd_en <= i_wb_dat[RDEN_BIT];
        end
    end

    // Drain starts on the eof write and runs until the receive FIFO is empty
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            drain <= 1'b0;
        end
        else if (o_rx_push & i_wb_dat[EOF_BIT])
        begin
            drain <= 1'b1;
        end
        else if (i_rx_empty)
        begin
            drain <= 1'b0;
        end
    end

    // A whole result frame is waiting once its eof word is stored
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            readable <= 1'b0;
        end
        else if (i_res_eof_accepted)
        begin
            readable <= 1'b1;
        end
        else if (i_tx_empty)
        begin
            readable <= 1'b0;
        end
    end

    always_comb
    begin
        rdata            = '0;
        rdata[AVAIL_BIT] = readable;
        rdata[ALIVE_BIT] = 1'b1;
        rdata[7:0]       = i_tx_head;
    end

    assign o_wb_ack = ack;
    assign o_wb_dat = rdata;
    assign o_drain  = drain;

endmodule

// File: hdl/code_param_rom.sv
// Registered code-parameter table indexed by selector
`include "tenc_cfg.svh"

module code_param_rom
    import tenc_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  code_sel_t  i_sel,
    output blocksize_t o_blocksize,
    output perm_p_t    o_p,
    output perm_q_t    o_q0,
    output perm_q_t    o_q1,
    output perm_q_t    o_q2,
    output perm_q_t    o_q3
);
    typedef struct packed {
        blocksize_t blocksize;
        perm_p_t    p;
        perm_q_t    q0;
        perm_q_t    q1;
        perm_q_t    q2;
        perm_q_t    q3;
    } code_entry_t;

    code_entry_t entry;

    // Fields in order: block size, p, q0, q1, q2, q3
    function automatic code_entry_t lookup(input code_sel_t sel);
        code_entry_t e;
        case (sel)
            6'd0:        e = '{10'd14,  10'd9,  12'd3, 12'd11, 12'd51,  12'd19};
            6'd1:        e = '{10'd38,  10'd17, 12'd3, 12'd23, 12'd63,  12'd11};
            6'd2:        e = '{10'd51,  10'd23, 12'd3, 12'd23, 12'd107, 12'd107};
            6'd3:        e = '{10'd55,  10'd23, 12'd3, 12'd43, 12'd131, 12'd115};
            6'd4, 6'd33: e = '{10'd59,  10'd23, 12'd3, 12'd11, 12'd23,  12'd219};
            6'd5:        e = '{10'd62,  10'd23, 12'd3, 12'd35, 12'd63,  12'd63};
            6'd6:        e = '{10'd69,  10'd25, 12'd3, 12'd7,  12'd111, 12'd103};
            6'd7:        e = '{10'd84,  10'd23, 12'd3, 12'd7,  12'd83,  12'd71};
            6'd8:        e = '{10'd85,  10'd23, 12'd3, 12'd55, 12'd255, 12'd215};
            6'd9:        e = '{10'd93,  10'd25, 12'd3, 12'd31, 12'd111, 12'd107};
            6'd10:       e = '{10'd96,  10'd25, 12'd3, 12'd11, 12'd103, 12'd107};
            6'd11:       e = '{10'd100, 10'd23, 12'd3, 12'd35, 12'd131, 12'd127};
            6'd12:       e = '{10'd108, 10'd29, 12'd3, 12'd19, 12'd123, 12'd123};
            6'd13:       e = '{10'd115, 10'd29, 12'd3, 12'd23, 12'd239, 12'd239};
            6'd14:       e = '{10'd123, 10'd31, 12'd3, 12'd15, 12'd7,   12'd3};
            6'd15:       e = '{10'd128, 10'd31, 12'd3, 12'd7,  12'd135, 12'd131};
            6'd16:       e = '{10'd130, 10'd31, 12'd3, 12'd7,  12'd11,  12'd3};
            6'd17:       e = '{10'd144, 10'd31, 12'd3, 12'd3,  12'd3,   12'd3};
            6'd18:       e = '{10'd170, 10'd33, 12'd3, 12'd63, 12'd523, 12'd515};
            6'd19:       e = '{10'd175, 10'd37, 12'd3, 12'd11, 12'd3,   12'd11};
            6'd20:       e = '{10'd188, 10'd37, 12'd3, 12'd15, 12'd167, 12'd159};
            6'd21:       e = '{10'd192, 10'd37, 12'd3, 12'd7,  12'd183, 12'd123};
            6'd22:       e = '{10'd194, 10'd39, 12'd3, 12'd3,  12'd319, 12'd319};
            6'd23:       e = '{10'd256, 10'd45, 12'd3, 12'd7,  12'd199, 12'd183};
            6'd24:       e = '{10'd264, 10'd43, 12'd3, 12'd3,  12'd27,  12'd11};
            6'd25:       e = '{10'd298, 10'd49, 12'd3, 12'd15, 12'd23,  12'd3};
            6'd26:       e = '{10'd307, 10'd49, 12'd3, 12'd27, 12'd3,   12'd7};
            6'd27:       e = '{10'd333, 10'd49, 12'd3, 12'd23, 12'd3,   12'd23};
            6'd28:       e = '{10'd355, 10'd53, 12'd3, 12'd19, 12'd239, 12'd223};
            6'd29:       e = '{10'd400, 10'd53, 12'd3, 12'd43, 12'd243, 12'd219};
            6'd30:       e = '{10'd438, 10'd59, 12'd3, 12'd7,  12'd247, 12'd243};
            6'd31:       e = '{10'd444, 10'd59, 12'd3, 12'd35, 12'd731, 12'd715};
            6'd32:       e = '{10'd539, 10'd65, 12'd3, 12'd15, 12'd31,  12'd3};
            default:     e = '0;
        endcase
        return e;
    endfunction

    // Out-of-range selectors give an all-zero configuration
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            entry <= '0;
        end
        else if (i_sel < `TENC_NUM_CODES)
        begin
            entry <= lookup(i_sel);
        end
        else
        begin
            entry <= '0;
        end
    end

    assign o_blocksize = entry.blocksize;
    assign o_p         = entry.p;
    assign o_q0        = entry.q0;
    assign o_q1        = entry.q1;
    assign o_q2        = entry.q2;
    assign o_q3        = entry.q3;

endmodule

// File: hdl/tenc_bridge_top.sv
// Bus bridge top: register block, receive and transmit FIFOs, code-parameter table
`include "tenc_cfg.svh"

module tenc_bridge_top
    import tenc_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    // Wishbone slave
    input  logic       i_wb_cyc,
    input  logic       i_wb_stb,
    input  logic       i_wb_we,
    input  wb_data_t   i_wb_dat,
    output logic       o_wb_ack,
    output wb_data_t   o_wb_dat,
    // Code selection
    input  code_sel_t  i_param_sel,
    // Symbol stream toward the encoder
    output logic       o_enc_valid,
    input  logic       i_enc_ready,
    output in_sym_t    o_enc_sym,
    // Result stream from the encoder
    input  logic       i_res_valid,
    output logic       o_res_ready,
    input  res_word_t  i_res_word,
    // Encoder configuration
    output blocksize_t o_blocksize,
    output perm_p_t    o_p,
    output perm_q_t    o_q0,
    output perm_q_t    o_q1,
    output perm_q_t    o_q2,
    output perm_q_t    o_q3
);
    logic      rx_push;
    in_sym_t   rx_sym;
    logic      rx_pop;
    logic      rx_empty;
    logic      drain;
    logic      tx_push;
    logic      tx_pop;
    logic      tx_full;
    logic      tx_empty;
    res_word_t tx_head;
    logic      res_eof_accepted;

    // Symbols are offered only once a full frame has been written
    assign o_enc_valid = drain & ~rx_empty;
    assign rx_pop      = o_enc_valid & i_enc_ready;

    // Encoder is held off while the transmit FIFO is full
    assign o_res_ready      = ~tx_full;
    assign tx_push          = i_res_valid & o_res_ready;
    assign res_eof_accepted = tx_push & i_res_word.eof;

    wb_regs u_regs (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_wb_cyc           (i_wb_cyc),
        .i_wb_stb           (i_wb_stb),
        .i_wb_we            (i_wb_we),
        .i_wb_dat           (i_wb_dat),
        .o_wb_ack           (o_wb_ack),
        .o_wb_dat           (o_wb_dat),
        .o_rx_push          (rx_push),
        .o_rx_sym           (rx_sym),
        .i_rx_empty         (rx_empty),
        .o_drain            (drain),
        .o_tx_pop           (tx_pop),
        .i_tx_head          (tx_head),
        .i_tx_empty         (tx_empty),
        .i_res_eof_accepted (res_eof_accepted)
    );

    sync_fifo #(
        .payload_t (in_sym_t),
        .ADDR_W    (`TENC_RX_DEPTH_LOG2)
    ) u_rx_fifo (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wr     (rx_push),
        .i_rd     (rx_pop),
        .i_w_data (rx_sym),
        .o_r_data (o_enc_sym),
        .o_empty  (rx_empty),
        .o_full   ()
    );

    sync_fifo #(
        .payload_t (res_word_t),
        .ADDR_W    (`TENC_TX_DEPTH_LOG2)
    ) u_tx_fifo (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wr     (tx_push),
        .i_rd     (tx_pop),
        .i_w_data (i_res_word),
        .o_r_data (tx_head),
        .o_empty  (tx_empty),
        .o_full   (tx_full)
    );

    code_param_rom u_rom (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_sel       (i_param_sel),
        .o_blocksize (o_blocksize),
        .o_p         (o_p),
        .o_q0        (o_q0),
        .o_q1        (o_q1),
        .o_q2        (o_q2),
        .o_q3        (o_q3)
    );

endmodule

// File: dv/tenc_bridge_properties.sv
// Bound assertions on bus ack, symbol hold under back-pressure and out-of-range code selection
`include "tenc_cfg.svh"

module tenc_bridge_properties
    import tenc_pkg::*;
(
    input logic       i_clk,
    input logic       i_rst,
    input logic       i_wb_ack,
    input logic       i_enc_valid,
    input logic       i_enc_ready,
    input in_sym_t    i_enc_sym,
    input code_sel_t  i_param_sel,
    input blocksize_t i_blocksize,
    input perm_p_t    i_p,
    input perm_q_t    i_q0,
    input perm_q_t    i_q1,
    input perm_q_t    i_q2,
    input perm_q_t    i_q3
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Every request gets exactly one ack cycle
    ack_single: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_ack |=> !i_wb_ack)
    else
    begin
        fail_count++;
        $error("bus ack high on two consecutive cycles");
    end

    // Offered symbol stays put until the encoder takes it
    sym_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_enc_valid && !i_enc_ready) |=> (i_enc_valid && $stable(i_enc_sym)))
    else
    begin
        fail_count++;
        $error("encoder symbol changed while stalled");
    end

    cfg_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_param_sel >= `TENC_NUM_CODES) |=>
            (i_blocksize == '0 && i_p == '0 && i_q0 == '0 &&
             i_q1 == '0 && i_q2 == '0 && i_q3 == '0))
    else
    begin
        fail_count++;
        $error("configuration not zero after an out-of-range selector");
    end

endmodule

bind tenc_bridge_top tenc_bridge_properties u_props (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_wb_ack    (o_wb_ack),
    .i_enc_valid (o_enc_valid),
    .i_enc_ready (i_enc_ready),
    .i_enc_sym   (o_enc_sym),
    .i_param_sel (i_param_sel),
    .i_blocksize (o_blocksize),
    .i_p         (o_p),
    .i_q0        (o_q0),
    .i_q1        (o_q1),
    .i_q2        (o_q2),
    .i_q3        (o_q3)
);

// File: dv/tenc_bridge_tb.sv
// Directed testbench for the bus bridge, with the encoder stream model, tests and timeout
module tenc_bridge_tb
    import tenc_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // The tests need about 250 cycles, the limit leaves a wide margin
    localparam int CYCLE_LIMIT = 4000;

    logic       clk;
    logic       rst;
    logic       cyc;
    logic       stb;
    logic       we;
    wb_data_t   wb_dat_in;
    logic       wb_ack;
    wb_data_t   wb_dat_out;
    code_sel_t  param_sel;
    logic       enc_valid;
    logic       enc_ready;
    in_sym_t    enc_sym;
    logic       res_valid;
    logic       res_ready;
    res_word_t  res_word;
    blocksize_t blocksize;
    perm_p_t    p;
    perm_q_t    q0;
    perm_q_t    q1;
    perm_q_t    q2;
    perm_q_t    q3;

    integer     seed = 81;
    int         cycles;
    logic       eof_sent;
    in_sym_t    seen_syms[$];

    tenc_bridge_top i_dut (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_wb_cyc    (cyc),
        .i_wb_stb    (stb),
        .i_wb_we     (we),
        .i_wb_dat    (wb_dat_in),
        .o_wb_ack    (wb_ack),
        .o_wb_dat    (wb_dat_out),
        .i_param_sel (param_sel),
        .o_enc_valid (enc_valid),
        .i_enc_ready (enc_ready),
        .o_enc_sym   (enc_sym),
        .i_res_valid (res_valid),
        .o_res_ready (res_ready),
        .i_res_word  (res_word),
        .o_blocksize (blocksize),
        .o_p         (p),
        .o_q0        (q0),
        .o_q1        (q1),
        .o_q2        (q2),
        .o_q3        (q3)
    );

    always #4 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            fail_now($sformatf("simulation timeout after %0d cycles", cycles));
        end
    end

    // Encoder model, random back-pressure on the symbol stream
    always @(posedge clk)
    begin
        #1;
        enc_ready = ($random(seed) & 1) != 0;
    end

    // Mid-cycle sample of the symbol handshake taken at the next edge
    always @(negedge clk)
    begin
        if (!rst && enc_valid)
        begin
            if (!eof_sent)
            begin
                fail_now("symbol offered at the encoder port before the eof write");
            end
            else if (enc_ready)
            begin
                seen_syms.push_back(enc_sym);
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_now($sformatf("mismatch %s: expected %b actual %b", name, exp, act));
    endtask

    task automatic check_sym(input string name, input in_sym_t exp, input in_sym_t act);
        if (act !== exp)
            fail_now($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_res(input string name, input res_word_t exp, input res_word_t act);
        if (act !== exp)
            fail_now($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
        if (act !== exp)
            fail_now($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_blocksize(input string name, input blocksize_t exp,
                                   input blocksize_t act);
        if (act !== exp)
            fail_now($sformatf("mismatch %s: expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_p(input string name, input perm_p_t exp, input perm_p_t act);
        if (act !== exp)
            fail_now($sformatf("mismatch %s: expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_q(input string name, input perm_q_t exp, input perm_q_t act);
        if (act !== exp)
            fail_now($sformatf("mismatch %s: expected %0d actual %0d", name, exp, act));
    endtask

    // Bus write word that pushes one symbol
    function automatic wb_data_t sym_write_word(input in_sym_t s);
        wb_data_t w;
        w      = '0;
        w[15]  = 1'b1;
        w[7]   = s.eof;
        w[6]   = s.bof;
        w[1:0] = s.data;
        return w;
    endfunction

    // Read word with readable flag, alive bit and transmit head
    function automatic wb_data_t status_word(input logic readable, input res_word_t head);
        wb_data_t w;
        w      = '0;
        w[15]  = readable;
        w[14]  = 1'b1;
        w[7:0] = head;
        return w;
    endfunction

    // One Wishbone request, called and returning one step after a rising edge
    task automatic bus_cycle(input logic write, input wb_data_t data, output wb_data_t rdata);
        int waited;
        waited    = 0;
        cyc       = 1'b1;
        stb       = 1'b1;
        we        = write;
        wb_dat_in = data;
        next_cycle();
        while (!wb_ack)
        begin
            waited++;
            if (waited > 16)
                fail_now("no bus acknowledge within 16 cycles");
            else
                next_cycle();
        end
        rdata = wb_dat_out;
        // Request stays up through the ack cycle
        next_cycle();
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        wb_dat_in = '0;
    endtask

    task automatic push_result(input res_word_t w);
        int waited;
        waited    = 0;
        res_valid = 1'b1;
        res_word  = w;
        while (!res_ready)
        begin
            waited++;
            if (waited > 16)
                fail_now("result stream not ready within 16 cycles");
            else
                next_cycle();
        end
        next_cycle();
        res_valid = 1'b0;
    endtask

    task automatic test_reset();
        wb_data_t rdata;
        check_flag("reset ack", 1'b0, wb_ack);
        check_flag("reset enc valid", 1'b0, enc_valid);
        check_flag("reset res ready", 1'b1, res_ready);
        bus_cycle(1'b0, '0, rdata);
        // Head byte is undefined before any result arrives
        check_word("reset status", 32'h0000_4000, rdata & 32'hFFFF_FF00);
    endtask

    task automatic test_frame();
        in_sym_t  exp_syms[6];
        wb_data_t rdata;
        int       waited;
        for (int i = 0; i < 6; i++)
        begin
            exp_syms[i].bof  = (i == 0);
            exp_syms[i].eof  = (i == 5);
            exp_syms[i].data = 2'(i) ^ 2'b01;
        end
        for (int i = 0; i < 6; i++)
        begin
            if (i == 5)
                eof_sent = 1'b1;
            bus_cycle(1'b1, sym_write_word(exp_syms[i]), rdata);
        end
        waited = 0;
        while (seen_syms.size() < 6)
        begin
            waited++;
            if (waited > 200)
                fail_now("frame symbols did not all reach the encoder port");
            else
                next_cycle();
        end
        for (int i = 0; i < 6; i++)
            check_sym($sformatf("frame symbol %0d", i), exp_syms[i], seen_syms[i]);
    endtask

    task automatic test_results();
        res_word_t words[5];
        wb_data_t  rdata;
        for (int i = 0; i < 5; i++)
        begin
            words[i].bof  = (i == 0);
            words[i].eof  = (i == 4);
            words[i].data = 6'(i * 9 + 5);
            push_result(words[i]);
        end
        bus_cycle(1'b0, '0, rdata);
        check_word("result status", 32'h0000_C000, rdata & 32'hFFFF_FF00);
        check_res("result first head", words[0], res_word_t'(rdata[7:0]));
        // Write with bit 13 turns on popping for the following reads
        bus_cycle(1'b1, 32'h0000_2000, rdata);
        for (int i = 0; i < 5; i++)
        begin
            bus_cycle(1'b0, (i < 4) ? 32'h0000_2000 : 32'h0, rdata);
            check_word($sformatf("result read %0d", i), status_word(1'b1, words[i]), rdata);
        end
        bus_cycle(1'b0, '0, rdata);
        check_word("result drained", 32'h0000_4000, rdata & 32'hFFFF_FF00);
    endtask

    task automatic test_hold_head();
        res_word_t words[2];
        wb_data_t  first;
        wb_data_t  second;
        for (int i = 0; i < 2; i++)
        begin
            words[i].bof  = (i == 0);
            words[i].eof  = (i == 1);
            words[i].data = 6'(40 + i);
            push_result(words[i]);
        end
        bus_cycle(1'b0, '0, first);
        bus_cycle(1'b0, '0, second);
        check_word("hold first read", status_word(1'b1, words[0]), first);
        check_word("hold second read", status_word(1'b1, words[0]), second);
    endtask

    task automatic check_params(input string name, input code_sel_t sel,
                                input blocksize_t exp_bs, input perm_p_t exp_p,
                                input perm_q_t e0, input perm_q_t e1,
                                input perm_q_t e2, input perm_q_t e3);
        param_sel = sel;
        next_cycle();
        check_blocksize({name, " blocksize"}, exp_bs, blocksize);
        check_p({name, " p"}, exp_p, p);
        check_q({name, " q0"}, e0, q0);
        check_q({name, " q1"}, e1, q1);
        check_q({name, " q2"}, e2, q2);
        check_q({name, " q3"}, e3, q3);
    endtask

    task automatic test_params();
        check_params("sel 0", 6'd0, 10'd14, 10'd9, 12'd3, 12'd11, 12'd51, 12'd19);
        check_params("sel 17", 6'd17, 10'd144, 10'd31, 12'd3, 12'd3, 12'd3, 12'd3);
        // Last entry repeats entry 4
        check_params("sel 33", 6'd33, 10'd59, 10'd23, 12'd3, 12'd11, 12'd23, 12'd219);
        check_params("sel 40", 6'd40, '0, '0, '0, '0, '0, '0);
        // One more edge so the zero check on the out-of-range selector completes
        next_cycle();
    endtask

    initial
    begin
        clk       = 1'b0;
        rst       = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        wb_dat_in = '0;
        param_sel = '0;
        enc_ready = 1'b0;
        res_valid = 1'b0;
        res_word  = '0;
        cycles    = 0;
        eof_sent  = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_frame();
        test_results();
        test_hold_head();
        test_params();
        if (i_dut.u_props.fail_count == 0)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
        begin
            fail_now("bound property checks reported failures");
        end
    end

endmodule

// File: filelist.f
+incdir+hdl
hdl/tenc_pkg.sv
hdl/sync_fifo.sv
hdl/wb_regs.sv
hdl/code_param_rom.sv
hdl/tenc_bridge_top.sv
dv/tenc_bridge_properties.sv
dv/tenc_bridge_tb.sv

// File: run.sh
#!/bin/sh
# Build the bridge testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tenc_bridge_tb \
    -Mdir obj_dir \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtenc_bridge_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
